// ==== include/stride_defs.svh ====
// Size macros for address, data, memory, port count and credits of the strided load unit
`ifndef STRIDE_DEFS_SVH
`define STRIDE_DEFS_SVH

//////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////

// Word address bits with addressing modulo 2**10
`define STRIDE_ADDR_W      10

// One scratchpad word
`define STRIDE_DATA_W      32

// Full address space is backed
`define STRIDE_MEM_DEPTH   1024

//////////////////////////////////////////////////
// Lane interface
//////////////////////////////////////////////////

`define STRIDE_PORTS       3          // Requesters sharing the port
`define STRIDE_CREDITS     4          // Consumer credits after reset

`endif

// ==== design/stride_pkg.sv ====
// Shared descriptor, read request and output beat types of the strided load unit
`default_nettype none

`include "stride_defs.svh"

package stride_pkg;

	//////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////

	typedef logic [`STRIDE_ADDR_W-1:0]          addr_t;     // Word address
	typedef logic [`STRIDE_DATA_W-1:0]          data_t;     // Memory word
	typedef logic [$clog2(`STRIDE_PORTS)-1:0]   port_id_t;  // Requester index

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////

	// Access descriptor as presented by a requester
	typedef struct packed {
		addr_t      base;       // First word
		addr_t      stride;     // Step between beats
		addr_t      length;     // Beat count where zero means one
	} access_desc_t;

	typedef struct packed {
		addr_t      addr;       // Word to read
		port_id_t   port_id;    // Owner of the beat
		logic       last;       // Final read of the access
	} rd_req_t;

	// Output stream word
	typedef struct packed {
		data_t      data;       // Read data
		port_id_t   port_id;    // Tag copied from request
		logic       last;       // End of access
	} beat_t;

endpackage

`default_nettype wire

// ==== design/access_arbiter.sv ====
// Fixed-priority arbiter that holds one requester's grant until its access is done
`default_nettype none

`include "stride_defs.svh"

module access_arbiter (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic [`STRIDE_PORTS-1:0]   req,                        // Per-port request
	input  wire stride_pkg::access_desc_t   desc [`STRIDE_PORTS],       // Per-port descriptor
	input  wire logic                       access_done,                // Last read issued
	output logic                            grant_valid,                // A grant is held
	output stride_pkg::port_id_t            grant_port,                 // Holder index
	output stride_pkg::access_desc_t        grant_desc,                 // Holder descriptor
	output logic [`STRIDE_PORTS-1:0]        done                        // Per-port done pulse
);

	import stride_pkg::*;

	logic [`STRIDE_PORTS-1:0]   grant;          // One-hot held grant
	logic [`STRIDE_PORTS-1:0]   win;            // Fixed-priority pick
	port_id_t                   held_id;        // Encoded holder

	//////////////////////////////////////////////////
	// Priority pick
	//////////////////////////////////////////////////

	// Lowest index among raised requests
	always_comb begin
		win = '0;
		for (int i = 0; i < `STRIDE_PORTS; i++) begin
			if (req[i] && (win == '0)) begin
				win[i] = 1'b1;                  // First hit wins
			end
		end
	end

	//////////////////////////////////////////////////
	// Grant registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			grant <= '0;
		end else if (access_done) begin
			grant <= '0;                        // Free the port for one cycle
		end else if (grant == '0) begin
			grant <= win;                       // Never preempts a held grant
		end
	end

	// One-hot to index
	always_comb begin
		held_id = '0;
		for (int i = 0; i < `STRIDE_PORTS; i++) begin
			if (grant[i]) begin
				held_id = port_id_t'(i);
			end
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	assign grant_valid = |grant;
	assign grant_port  = held_id;
	assign grant_desc  = grant_valid ? desc[held_id] : '0;    // Zero while idle

	// Done goes back only to the holder
	assign done        = access_done ? grant : '0;

endmodule

`default_nettype wire

// ==== design/stride_addr_gen.sv ====
// Address generator walking base plus multiples of stride, paced by consumer credits
`default_nettype none

`include "stride_defs.svh"

module stride_addr_gen (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       grant_valid,    // Arbiter holds a grant
	input  wire stride_pkg::port_id_t       grant_port,     // Granted requester
	input  wire stride_pkg::access_desc_t   grant_desc,     // Granted descriptor
	input  wire logic                       credit_return,  // One freed beat
	output logic                            access_done,    // With the last read
	output logic                            rd_valid,       // Read issued
	output stride_pkg::rd_req_t             rd_req          // Read address and tags
);

	import stride_pkg::*;

	localparam int CRED_W = $clog2(`STRIDE_CREDITS + 1);

	logic                   busy;           // Walking a descriptor
	addr_t                  cur_addr;       // Next word to read
	addr_t                  stride;
	addr_t                  remaining;      // Beats left incl. current
	port_id_t               port_id;        // Owner of the walk
	logic [CRED_W-1:0]      credits;        // Free slots at the consumer
	logic                   issue;          // Read goes out this cycle
	logic                   final_beat;     // Current read is the last

	assign issue      = busy && (credits != '0);
	assign final_beat = (remaining == addr_t'(1));

	//////////////////////////////////////////////////
	// Credit counter
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= CRED_W'(`STRIDE_CREDITS);    // Full after reset
		end else if (issue && !credit_return) begin
			credits <= credits - 1'b1;              // Spend
		end else if (!issue && credit_return) begin
			credits <= credits + 1'b1;              // Refill
		end
	end

	//////////////////////////////////////////////////
	// Descriptor walk
	//////////////////////////////////////////////////

	// Done still high means the finished grant is not yet dropped
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (!busy) begin
			busy <= grant_valid && !access_done;
		end else if (issue && final_beat) begin
			busy <= 1'b0;                           // Back to idle
		end
	end

	always_ff @(posedge clock) begin
		if (!busy) begin
			cur_addr  <= grant_desc.base;
			stride    <= grant_desc.stride;
			remaining <= (grant_desc.length == '0) ? addr_t'(1) : grant_desc.length;
			port_id   <= grant_port;
		end else if (issue) begin
			cur_addr  <= cur_addr + stride;         // Wraps at address width
			remaining <= remaining - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Read request register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_valid    <= 1'b0;
			access_done <= 1'b0;
		end else begin
			rd_valid    <= issue;
			access_done <= issue && final_beat;     // One-cycle pulse
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			rd_req.addr    <= cur_addr;
			rd_req.port_id <= port_id;
			rd_req.last    <= final_beat;
		end
	end

endmodule

`default_nettype wire

// ==== design/local_mem.sv ====
// Scratchpad with one write port and one single-cycle read port that forwards beat tags
`default_nettype none

`include "stride_defs.svh"

module local_mem (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   wr_en,          // Fill strobe
	input  wire stride_pkg::addr_t      wr_addr,
	input  wire stride_pkg::data_t      wr_data,
	input  wire logic                   rd_valid,       // Read request strobe
	input  wire stride_pkg::rd_req_t    rd_req,         // Address and tags
	output logic                        beat_valid,     // Read data ready
	output stride_pkg::beat_t           beat            // Data with tags
);

	import stride_pkg::*;

	data_t mem [`STRIDE_MEM_DEPTH];                     // Word array

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////

	// Valid follows the request by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= rd_valid;
		end
	end

	// Old data on a same-address write
	always_ff @(posedge clock) begin
		if (rd_valid) begin
			beat.data    <= mem[rd_req.addr];
			beat.port_id <= rd_req.port_id;         // Tag rides along
			beat.last    <= rd_req.last;
		end
	end

endmodule

`default_nettype wire

// ==== design/stride_load_unit.sv ====
// Strided load unit top joining arbiter, address generator and scratchpad into one beat stream
`default_nettype none

`include "stride_defs.svh"

module stride_load_unit (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic [`STRIDE_PORTS-1:0]   req,                    // Requester strobes
	input  wire stride_pkg::access_desc_t   desc [`STRIDE_PORTS],   // Requester descriptors
	output logic [`STRIDE_PORTS-1:0]        done,                   // Access finished
	input  wire logic                       credit_return,          // Consumer freed a beat
	input  wire logic                       wr_en,                  // Fill port
	input  wire stride_pkg::addr_t          wr_addr,
	input  wire stride_pkg::data_t          wr_data,
	output logic                            beat_valid,             // Output stream
	output stride_pkg::beat_t               beat
);

	import stride_pkg::*;

	logic           grant_valid;
	port_id_t       grant_port;
	access_desc_t   grant_desc;
	logic           access_done;    // Generator to arbiter
	logic           rd_valid;
	rd_req_t        rd_req;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	access_arbiter arbiter_i (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.desc        (desc),
		.access_done (access_done),
		.grant_valid (grant_valid),
		.grant_port  (grant_port),
		.grant_desc  (grant_desc),
		.done        (done)
	);

	stride_addr_gen addr_gen_i (
		.clock         (clock),
		.reset         (reset),
		.grant_valid   (grant_valid),
		.grant_port    (grant_port),
		.grant_desc    (grant_desc),
		.credit_return (credit_return),
		.access_done   (access_done),
		.rd_valid      (rd_valid),
		.rd_req        (rd_req)
	);

	local_mem mem_i (
		.clock      (clock),
		.reset      (reset),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_valid   (rd_valid),
		.rd_req     (rd_req),
		.beat_valid (beat_valid),
		.beat       (beat)
	);

endmodule

`default_nettype wire

// ==== verification/tb_stride_load_unit.sv ====
// Directed testbench for the strided load unit with a memory model and a credit consumer
`default_nettype none

`include "stride_defs.svh"

module tb_stride_load_unit;

	timeunit 1ns;
	timeprecision 1ps;

	import stride_pkg::*;

	localparam int TEST_BEATS      = 8 + 15 + 15 + 10 + 10;    // Beats in tests 2 to 6
	localparam int WATCHDOG_CYCLES = TEST_BEATS * 20 + 500;

	logic                       clock = 1'b0;
	logic                       reset;
	logic [`STRIDE_PORTS-1:0]   req;
	access_desc_t               desc [`STRIDE_PORTS];
	logic [`STRIDE_PORTS-1:0]   done;
	logic                       credit_return = 1'b0;
	logic                       wr_en;
	addr_t                      wr_addr;
	data_t                      wr_data;
	logic                       beat_valid;
	beat_t                      beat;

	data_t      model [`STRIDE_MEM_DEPTH];          // Words written before the tests
	beat_t      exp_q [$];                          // Beats still owed, in order
	int         seed = 32'h98b6_2664;
	int         errors = 0;
	int         checks = 0;
	int         beat_count = 0;
	int         done_count [`STRIDE_PORTS] = '{default: 0};
	logic       credit_en = 1'b1;                   // Consumer returns credits
	int         owed = 0;                           // Credits due back
	logic [1:0] credit_pipe = '0;                   // Two-cycle return delay

	always #4 clock = ~clock;                       // 8 ns period

	stride_load_unit dut_i (.*);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, want, got);
		end
	endtask

	// Served ports pulse done once since the snapshot, the others not at all
	task automatic check_done(input int d [`STRIDE_PORTS],
			input logic [`STRIDE_PORTS-1:0] served);
		for (int i = 0; i < `STRIDE_PORTS; i++) begin
			check_value($sformatf("done[%0d] pulses", i), 32'(served[i]),
				32'(done_count[i] - d[i]));
		end
	endtask

	// Raise a request and queue the beats that base + k * stride predicts
	task automatic post_request(input int p, input int base, input int stride, input int length);
		int n;
		beat_t b;
		n = (length == 0) ? 1 : length;                 // Zero length is one beat
		desc[p] = '{addr_t'(base), addr_t'(stride), addr_t'(length)};
		req[p] = 1'b1;
		for (int k = 0; k < n; k++) begin
			b.data    = model[(base + k * stride) % `STRIDE_MEM_DEPTH];   // Wraps at 1024
			b.port_id = port_id_t'(p);
			b.last    = (k == n - 1);
			exp_q.push_back(b);
		end
	endtask

	// Serve done pulses until every request is dropped and every beat seen
	task automatic wait_idle();
		logic [`STRIDE_PORTS-1:0] seen;
		seen = '0;
		while (req != '0 || exp_q.size() != 0) begin
			@(negedge clock);
			req  = req & ~seen;                         // Drop req the cycle after done
			seen = done;
		end
		repeat (6) @(negedge clock);                    // Last credits drain
	endtask

	// Beat compare against the queue and done counting
	always @(negedge clock) begin
		beat_t want;
		if (beat_valid === 1'b1) begin
			beat_count++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("%0t: a beat arrived with no access outstanding", $time);
			end else begin
				want = exp_q.pop_front();
				check_value("beat.data", want.data, beat.data);
				check_value("beat.port_id", 32'(want.port_id), 32'(beat.port_id));
				check_value("beat.last", 32'(want.last), 32'(beat.last));
			end
		end
		for (int i = 0; i < `STRIDE_PORTS; i++) begin
			if (done[i] === 1'b1) begin
				done_count[i]++;
			end
		end
	end

	// One credit back two cycles after each beat and held while disabled
	always @(negedge clock) begin
		if (credit_pipe[1]) begin
			owed++;
		end
		credit_pipe   = {credit_pipe[0], beat_valid === 1'b1};
		credit_return = credit_en && (owed > 0);
		if (credit_return) begin
			owed--;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog fired after %0d cycles with the DUT still busy", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_idle();
		int e;
		e = errors;
		repeat (10) begin
			@(negedge clock);
			check_value("beat_valid", 32'd0, 32'(beat_valid));
			check_value("done", 32'd0, 32'(done));
		end
		$display("test 1 idle after reset: %0d errors", errors - e);
	endtask

	task automatic test_single();
		int e;
		int d [`STRIDE_PORTS];
		e = errors;
		d = done_count;
		post_request(1, 5, 3, 8);
		wait_idle();
		check_done(d, 3'b010);
		$display("test 2 single strided access: %0d errors", errors - e);
	endtask

	task automatic test_order();
		int e;
		int d [`STRIDE_PORTS];
		e = errors;
		d = done_count;
		post_request(0, 100, 1, 4);                     // All three in one cycle
		post_request(1, 300, 5, 5);
		post_request(2, 600, 11, 6);
		wait_idle();                                    // Queue order is port order
		check_done(d, 3'b111);
		$display("test 3 fixed priority order: %0d errors", errors - e);
	endtask

	task automatic test_hold();
		int e;
		int b;
		int d [`STRIDE_PORTS];
		e = errors;
		b = beat_count;
		d = done_count;
		post_request(2, 700, 13, 12);
		while (beat_count < b + 2) begin
			@(negedge clock);                           // Port 2 is streaming
		end
		post_request(0, 50, 4, 3);                      // Must wait behind port 2
		wait_idle();
		check_done(d, 3'b101);
		$display("test 4 no preemption: %0d errors", errors - e);
	endtask

	task automatic test_credit();
		int e;
		int b;
		int d [`STRIDE_PORTS];
		e = errors;
		b = beat_count;
		d = done_count;
		credit_en = 1'b0;
		post_request(1, 40, 2, 10);
		repeat (20) @(negedge clock);                   // Issue stalls at zero credits
		check_value("beats without credit", 32'(`STRIDE_CREDITS), 32'(beat_count - b));
		credit_en = 1'b1;
		wait_idle();
		check_done(d, 3'b010);
		$display("test 5 credit back-pressure: %0d errors", errors - e);
	endtask

	task automatic test_edges();
		int e;
		int d [`STRIDE_PORTS];
		e = errors;
		d = done_count;
		post_request(0, 100, 0, 5);                     // Same word five times
		post_request(1, 200, 9, 0);                     // Single beat
		post_request(2, 1020, 7, 4);                    // Crosses the top of memory
		wait_idle();
		check_done(d, 3'b111);
		$display("test 6 edge descriptors: %0d errors", errors - e);
	endtask

	initial begin
		reset   = 1'b1;
		req     = '0;
		desc    = '{default: '0};
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		test_idle();
		wr_en = 1'b1;                                   // Fill through the write port
		for (int a = 0; a < `STRIDE_MEM_DEPTH; a++) begin
			model[a] = $random(seed);
			wr_addr  = addr_t'(a);
			wr_data  = model[a];
			@(negedge clock);
		end
		wr_en = 1'b0;
		test_single();
		test_order();
		test_hold();
		test_credit();
		test_edges();
		$display("checks %0d, errors %0d, beats %0d", checks, errors, beat_count);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
design/stride_pkg.sv
design/access_arbiter.sv
design/stride_addr_gen.sv
design/local_mem.sv
design/stride_load_unit.sv
verification/tb_stride_load_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_stride_load_unit -o tb_sim
./obj_dir/tb_sim | tee sim.log
grep -qx "TEST OK" sim.log
